//--- common/fir_pkg.sv
// Shared constants for the symmetric FIR filter.
// Widths, the Wishbone register map and the control bit position.
// Modules refer to these by scoped name.

package fir_pkg;

	// **************************************************
	// data path widths
	// **************************************************

	// input, output and coefficient samples, signed
	localparam int SAMPLE_W = 18;

	// full product of two SAMPLE_W operands
	localparam int PROD_W = 36;

	// **************************************************
	// wishbone bus
	// **************************************************

	localparam int WB_DAT_W = 32;

	// word address, not byte address
	localparam int WB_ADR_W = 5;

	// **************************************************
	// register map
	// **************************************************

	// coefficient k lives at ADR_COEF_BASE + k
	// and applies to taps k and NUM_TAPS-1-k
	localparam int ADR_COEF_BASE = 0;

	// control register
	localparam int ADR_CTRL = 16;

	// filter advances only while this bit is set
	localparam int CTRL_RUN_BIT = 0;

endpackage

//--- fir/fir_tap_line.sv
// Sample delay line and symmetric pre-adders of the FIR filter.
// Each step shifts in one sample, then registers the mirrored pair sums.
// The middle tap of an odd-length filter passes through unpaired.
`timescale 1ns/1ps

module fir_tap_line #(
	parameter int NUM_TAPS = 17,
	localparam int NUM_UNIQ = (NUM_TAPS + 1) / 2
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      i_step,
	input  logic signed [fir_pkg::SAMPLE_W-1:0]       i_sample,
	output logic [NUM_UNIQ*(fir_pkg::SAMPLE_W+1)-1:0] o_pair_sums
);

	localparam int SW = fir_pkg::SAMPLE_W;

	// pairs that have a mirror partner
	localparam int NUM_PAIRS = NUM_TAPS / 2;

	logic signed [SW-1:0] taps   [NUM_TAPS];
	logic signed [SW:0]   pair_q [NUM_UNIQ];

	// **************************************************
	// tap delay line
	// **************************************************

	// taps[t] holds x[n-t]
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int t = 0; t < NUM_TAPS; t++) begin
				taps[t] <= '0;
			end
		end else if (i_step) begin
			taps[0] <= i_sample;
			for (int t = 1; t < NUM_TAPS; t++) begin
				taps[t] <= taps[t-1];
			end
		end
	end

	// **************************************************
	// pre-adders
	// **************************************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				pair_q[k] <= '0;
			end
		end else if (i_step) begin
			// one extra bit keeps the pair sum exact
			for (int k = 0; k < NUM_PAIRS; k++) begin
				pair_q[k] <= taps[k] + taps[NUM_TAPS-1-k];
			end
			// bye register for the middle tap
			if (NUM_UNIQ > NUM_PAIRS) begin
				pair_q[NUM_UNIQ-1] <= taps[NUM_UNIQ-1];
			end
		end
	end

	for (genvar k = 0; k < NUM_UNIQ; k++) begin : g_pair_out
		assign o_pair_sums[k*(SW+1) +: SW+1] = pair_q[k];
	end

endmodule

//--- fir/fir_mac_tree.sv
// Multipliers and pipelined adder tree of the FIR filter.
// One multiplier per unique coefficient, then a registered binary tree
// that reduces the products one level per step, growing one bit per level.
`timescale 1ns/1ps

module fir_mac_tree #(
	parameter int NUM_TAPS = 17,
	localparam int NUM_UNIQ = (NUM_TAPS + 1) / 2,
	localparam int TREE_LEVELS = $clog2(NUM_UNIQ),
	localparam int ACC_W = fir_pkg::PROD_W + 1 + TREE_LEVELS
) (
	input  logic                                      clk,
	input  logic                                      i_step,
	input  logic [NUM_UNIQ*(fir_pkg::SAMPLE_W+1)-1:0] i_pair_sums,
	input  logic [NUM_UNIQ*fir_pkg::SAMPLE_W-1:0]     i_coefs,
	output logic signed [ACC_W-1:0]                   o_acc
);

	localparam int SW = fir_pkg::SAMPLE_W;

	// pair sum carries one bit more than a sample, so does its product
	localparam int MUL_W = fir_pkg::PROD_W + 1;

	// number of nodes at a tree level, level 0 being the products
	function automatic int level_count(input int level);
		int step_size;
		step_size = 1 << level;
		return (NUM_UNIQ + step_size - 1) / step_size;
	endfunction

	// **************************************************
	// tree levels
	// **************************************************

	for (genvar l = 0; l <= TREE_LEVELS; l++) begin : lvl
		localparam int W = MUL_W + l;
		localparam int CNT = level_count(l);

		logic signed [W-1:0] node [CNT];

		if (l == 0) begin : g_mul
			// level 0 is the multiplier register
			for (genvar i = 0; i < CNT; i++) begin : g_node
				logic signed [SW:0]   pair;
				logic signed [SW-1:0] coef;

				assign pair = $signed(i_pair_sums[i*(SW+1) +: SW+1]);
				assign coef = $signed(i_coefs[i*SW +: SW]);

				always_ff @(posedge clk) begin
					if (i_step) begin
						node[i] <= pair * coef;
					end
				end
			end
		end else begin : g_add
			localparam int PREV = level_count(l - 1);

			for (genvar i = 0; i < CNT; i++) begin : g_node
				if (2 * i + 1 < PREV) begin : g_sum
					always_ff @(posedge clk) begin
						if (i_step) begin
							node[i] <= lvl[l-1].node[2*i] + lvl[l-1].node[2*i+1];
						end
					end
				end else begin : g_bye
					// odd element rides along to keep alignment
					always_ff @(posedge clk) begin
						if (i_step) begin
							node[i] <= lvl[l-1].node[2*i];
						end
					end
				end
			end
		end
	end

	assign o_acc = lvl[TREE_LEVELS].node[0];

endmodule

//--- fir/fir_core.sv
// FIR filter core, tap line and MAC tree plus the valid delay line.
// Every pipeline register advances only on a step, i_ena and run both high.
// The final register shifts the accumulator by COEF_FRAC and saturates.
`timescale 1ns/1ps

module fir_core #(
	parameter int NUM_TAPS = 17,
	parameter int COEF_FRAC = 17,
	localparam int NUM_UNIQ = (NUM_TAPS + 1) / 2
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  i_ena,
	input  logic                                  i_run,
	input  logic                                  i_valid,
	input  logic signed [fir_pkg::SAMPLE_W-1:0]   i_sample,
	input  logic [NUM_UNIQ*fir_pkg::SAMPLE_W-1:0] i_coefs,
	output logic                                  o_valid,
	output logic signed [fir_pkg::SAMPLE_W-1:0]   o_sample
);

	localparam int SW = fir_pkg::SAMPLE_W;
	localparam int TREE_LEVELS = $clog2(NUM_UNIQ);
	localparam int ACC_W = fir_pkg::PROD_W + 1 + TREE_LEVELS;

	// tap line 2, multiply 1, tree levels, output register 1
	localparam int LATENCY = 4 + TREE_LEVELS;

	localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'((2 ** (SW - 1)) - 1);
	localparam logic signed [ACC_W-1:0] SAT_MIN = ~SAT_MAX;

	logic                         step;
	logic [NUM_UNIQ*(SW+1)-1:0]   pair_sums;
	logic signed [ACC_W-1:0]      acc;
	logic signed [ACC_W-1:0]      shifted;
	logic signed [SW-1:0]         sat;
	logic [LATENCY-1:0]           valid_q;

	assign step = i_ena & i_run;

	fir_tap_line #(.NUM_TAPS(NUM_TAPS)) u_tap_line (
		.clk         (clk),
		.reset       (reset),
		.i_step      (step),
		.i_sample    (i_sample),
		.o_pair_sums (pair_sums)
	);

	fir_mac_tree #(.NUM_TAPS(NUM_TAPS)) u_mac_tree (
		.clk         (clk),
		.i_step      (step),
		.i_pair_sums (pair_sums),
		.i_coefs     (i_coefs),
		.o_acc       (acc)
	);

	// **************************************************
	// scale, saturate and output
	// **************************************************

	// arithmetic shift rounds toward minus infinity
	assign shifted = acc >>> COEF_FRAC;

	always_comb begin
		if (shifted > SAT_MAX) begin
			sat = SAT_MAX[SW-1:0];
		end else if (shifted < SAT_MIN) begin
			sat = SAT_MIN[SW-1:0];
		end else begin
			sat = shifted[SW-1:0];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
			o_sample <= '0;
		end else if (step) begin
			valid_q <= {valid_q[LATENCY-2:0], i_valid};
			o_sample <= sat;
		end
	end

	assign o_valid = valid_q[LATENCY-1];

endmodule

//--- hw/fir_coef_regs.sv
// Wishbone classic slave for the FIR coefficient bank and control register.
// Ack comes one clock after the request, writes land on that same edge.
// Coefficients and the run bit feed the filter core directly.
`timescale 1ns/1ps

module fir_coef_regs #(
	parameter int NUM_TAPS = 17,
	localparam int NUM_UNIQ = (NUM_TAPS + 1) / 2
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic                                        i_wb_cyc,
	input  logic                                        i_wb_stb,
	input  logic                                        i_wb_we,
	input  logic [fir_pkg::WB_ADR_W-1:0]                i_wb_adr,
	input  logic [fir_pkg::WB_DAT_W-1:0]                i_wb_dat,
	output logic [fir_pkg::WB_DAT_W-1:0]                o_wb_dat,
	output logic                                        o_wb_ack,
	output logic [NUM_UNIQ*fir_pkg::SAMPLE_W-1:0]       o_coefs,
	output logic                                        o_run
);

	localparam int AW = fir_pkg::WB_ADR_W;
	localparam int DW = fir_pkg::WB_DAT_W;
	localparam int SW = fir_pkg::SAMPLE_W;

	logic signed [SW-1:0] coef_q [NUM_UNIQ];
	logic                 run_q;
	logic                 req;
	logic                 take;
	logic [DW-1:0]        rd_data;

	assign req = i_wb_cyc & i_wb_stb;

	// first cycle of a request, ack drops right after
	assign take = req & ~o_wb_ack;

	// **************************************************
	// ack and register writes
	// **************************************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_wb_ack <= 1'b0;
			run_q <= 1'b0;
			for (int k = 0; k < NUM_UNIQ; k++) begin
				coef_q[k] <= '0;
			end
		end else begin
			o_wb_ack <= take;
			if (take && i_wb_we) begin
				for (int k = 0; k < NUM_UNIQ; k++) begin
					if (i_wb_adr == AW'(fir_pkg::ADR_COEF_BASE + k)) begin
						coef_q[k] <= i_wb_dat[SW-1:0];
					end
				end
				if (i_wb_adr == AW'(fir_pkg::ADR_CTRL)) begin
					run_q <= i_wb_dat[fir_pkg::CTRL_RUN_BIT];
				end
			end
		end
	end

	// **************************************************
	// read mux
	// **************************************************

	// unmapped addresses fall through as zero
	always_comb begin
		rd_data = '0;
		for (int k = 0; k < NUM_UNIQ; k++) begin
			if (i_wb_adr == AW'(fir_pkg::ADR_COEF_BASE + k)) begin
				rd_data = {{(DW - SW){coef_q[k][SW-1]}}, coef_q[k]};
			end
		end
		if (i_wb_adr == AW'(fir_pkg::ADR_CTRL)) begin
			rd_data[fir_pkg::CTRL_RUN_BIT] = run_q;
		end
	end

	// captured with the ack so data is valid while ack is high
	always_ff @(posedge clk) begin
		if (take) begin
			o_wb_dat <= rd_data;
		end
	end

	for (genvar k = 0; k < NUM_UNIQ; k++) begin : g_coef_out
		assign o_coefs[k*SW +: SW] = coef_q[k];
	end

	assign o_run = run_q;

endmodule

//--- hw/fir_top.sv
// Top level of the Wishbone-loaded symmetric FIR filter.
// The host loads coefficients and sets run over Wishbone classic;
// samples stream in and out with i_ena as the only flow control.
`timescale 1ns/1ps

module fir_top #(
	parameter int NUM_TAPS = 17,
	parameter int COEF_FRAC = 17,
	localparam int NUM_UNIQ = (NUM_TAPS + 1) / 2
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                i_wb_cyc,
	input  logic                                i_wb_stb,
	input  logic                                i_wb_we,
	input  logic [fir_pkg::WB_ADR_W-1:0]        i_wb_adr,
	input  logic [fir_pkg::WB_DAT_W-1:0]        i_wb_dat,
	output logic [fir_pkg::WB_DAT_W-1:0]        o_wb_dat,
	output logic                                o_wb_ack,
	input  logic                                i_ena,
	input  logic                                i_valid,
	input  logic signed [fir_pkg::SAMPLE_W-1:0] i_sample,
	output logic                                o_valid,
	output logic signed [fir_pkg::SAMPLE_W-1:0] o_sample
);

	logic [NUM_UNIQ*fir_pkg::SAMPLE_W-1:0] coefs;
	logic                                  run;

	fir_coef_regs #(.NUM_TAPS(NUM_TAPS)) u_coef_regs (
		.clk      (clk),
		.reset    (reset),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we  (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.o_coefs  (coefs),
		.o_run    (run)
	);

	fir_core #(.NUM_TAPS(NUM_TAPS), .COEF_FRAC(COEF_FRAC)) u_core (
		.clk      (clk),
		.reset    (reset),
		.i_ena    (i_ena),
		.i_run    (run),
		.i_valid  (i_valid),
		.i_sample (i_sample),
		.i_coefs  (coefs),
		.o_valid  (o_valid),
		.o_sample (o_sample)
	);

endmodule

//--- verif/fir_tb.sv
// Testbench for the Wishbone-loaded symmetric FIR filter.
// Reads coefficients, input streams and expected outputs from verif/fir_cases.txt,
// runs every case once with continuous i_ena and once with random gaps.
`timescale 1ns/1ps

module fir_tb;

	localparam int NUM_TAPS = 17;
	localparam int COEF_FRAC = 17;
	localparam int NUM_UNIQ = (NUM_TAPS + 1) / 2;
	localparam int LATENCY = 4 + $clog2(NUM_UNIQ);
	localparam int SW = fir_pkg::SAMPLE_W;
	localparam int MEM_WORDS = 256;
	// worst case cycles per step with random gaps
	localparam int GAP_ALLOW = 4;
	localparam int REG_CYCLES = 120;

	logic                  clk;
	logic                  reset;
	logic                  i_wb_cyc;
	logic                  i_wb_stb;
	logic                  i_wb_we;
	logic [4:0]            i_wb_adr;
	logic [31:0]           i_wb_dat;
	logic [31:0]           o_wb_dat;
	logic                  o_wb_ack;
	logic                  i_ena;
	logic                  i_valid;
	logic signed [SW-1:0]  i_sample;
	logic                  o_valid;
	logic signed [SW-1:0]  o_sample;

	logic [31:0] cases_mem [0:MEM_WORDS-1];
	logic [31:0] exp_q [$];
	int          errors;
	int          checks;
	int          step_no;
	int          first_step;
	int          got;
	bit          stepped;
	bit          run_on;
	bit          monitor_on;
	logic        last_valid;
	logic [SW-1:0] last_sample;

	fir_top #(.NUM_TAPS(NUM_TAPS), .COEF_FRAC(COEF_FRAC)) dut (
		.clk      (clk),
		.reset    (reset),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we  (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.i_ena    (i_ena),
		.i_valid  (i_valid),
		.i_sample (i_sample),
		.o_valid  (o_valid),
		.o_sample (o_sample)
	);

	always #10 clk = ~clk;

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t ns: %s: got %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	function automatic logic [31:0] widen(input logic [SW-1:0] value);
		return {{(32 - SW){value[SW-1]}}, value};
	endfunction

	// **************************************************
	// step counter and output monitor
	// **************************************************

	always @(posedge clk) begin
		stepped <= i_ena && run_on;
		if (i_ena && run_on) begin
			step_no <= step_no + 1;
		end
	end

	// outputs change only on a step so each stepped edge carries one sample
	always @(negedge clk) begin
		if (monitor_on) begin
			if (stepped && o_valid) begin
				if (got == 0) begin
					check_value(step_no - first_step, LATENCY - 1, "steps to first output");
				end
				if (got < exp_q.size()) begin
					check_value(widen(o_sample), exp_q[got], "output sample");
				end else begin
					errors++;
					$display("unexpected extra output sample at %0t ns", $time);
				end
				got++;
			end else if (!stepped) begin
				check_value(32'(o_valid), 32'(last_valid), "o_valid held in gap");
				check_value(widen(o_sample), widen(last_sample), "o_sample held in gap");
			end
		end
		last_valid = o_valid;
		last_sample = o_sample;
	end

	// **************************************************
	// wishbone tasks
	// **************************************************

	task automatic bus_transfer(input logic we, input int adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int wait_cycles;
		@(negedge clk);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_adr = 5'(adr);
		i_wb_dat = wdat;
		wait_cycles = 0;
		do begin
			@(negedge clk);
			wait_cycles++;
		end while (!o_wb_ack && wait_cycles < 16);
		if (!o_wb_ack) begin
			errors++;
			$display("no Wishbone ack for address %0d", adr);
		end
		check_value(wait_cycles, 1, "cycles to ack");
		rdat = o_wb_dat;
		// a second ack must not follow while the request stays up
		@(negedge clk);
		check_value(32'(o_wb_ack), 0, "ack on two consecutive cycles");
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
	endtask

	task automatic bus_write(input int adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_transfer(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input int adr, output logic [31:0] rdat);
		bus_transfer(1'b0, adr, 32'h0, rdat);
	endtask

	// **************************************************
	// case sequencing
	// **************************************************

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		run_on = 1'b0;
		i_ena = 1'b0;
		i_valid = 1'b0;
		i_sample = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic stream_samples(input int base, input int n, input bit gaps);
		int idx;
		int flush;
		bit ena;
		idx = 0;
		got = 0;
		monitor_on = 1'b1;
		while (idx < n) begin
			@(negedge clk);
			ena = gaps ? ($urandom % 3 != 0) : 1'b1;
			i_ena = ena;
			i_valid = 1'b1;
			i_sample = cases_mem[base + idx][SW-1:0];
			if (ena) begin
				if (idx == 0) begin
					first_step = step_no + 1;
				end
				idx++;
			end
		end
		// zeros push the last samples out of the pipeline
		flush = 0;
		while (got < n && flush < 200) begin
			@(negedge clk);
			i_ena = gaps ? ($urandom % 3 != 0) : 1'b1;
			i_valid = 1'b0;
			i_sample = '0;
			flush++;
		end
		@(negedge clk);
		i_ena = 1'b0;
		monitor_on = 1'b0;
		check_value(got, n, "output count");
	endtask

	task automatic run_case(input int base, input bit gaps);
		int n;
		logic [31:0] rdat;
		n = cases_mem[base];
		apply_reset();
		for (int k = 0; k < NUM_UNIQ; k++) begin
			bus_write(fir_pkg::ADR_COEF_BASE + k, cases_mem[base + 1 + k]);
		end
		for (int k = 0; k < NUM_UNIQ; k++) begin
			bus_read(fir_pkg::ADR_COEF_BASE + k, rdat);
			check_value(rdat, cases_mem[base + 1 + k], "coefficient readback");
		end
		bus_read(fir_pkg::ADR_CTRL, rdat);
		check_value(rdat, 0, "control before run");
		bus_read(20, rdat);
		check_value(rdat, 0, "unmapped address");
		// nothing may come out while run is low
		repeat (12) begin
			@(negedge clk);
			i_ena = 1'b1;
			i_valid = 1'b1;
			i_sample = 18'sd1000;
			check_value(32'(o_valid), 0, "o_valid while stopped");
		end
		@(negedge clk);
		i_ena = 1'b0;
		i_valid = 1'b0;
		check_value(32'(o_valid), 0, "o_valid while stopped");
		bus_write(fir_pkg::ADR_CTRL, 32'h1 << fir_pkg::CTRL_RUN_BIT);
		run_on = 1'b1;
		bus_read(fir_pkg::ADR_CTRL, rdat);
		check_value(rdat, 32'h1 << fir_pkg::CTRL_RUN_BIT, "control run bit");
		exp_q.delete();
		for (int i = 0; i < n; i++) begin
			exp_q.push_back(cases_mem[base + 1 + NUM_UNIQ + n + i]);
		end
		stream_samples(base + 1 + NUM_UNIQ, n, gaps);
	endtask

	initial begin
		int ptr;
		int num_cases;
		int total;
		longint limit_ns;
		clk = 1'b0;
		reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		i_ena = 1'b0;
		i_valid = 1'b0;
		i_sample = '0;
		errors = 0;
		checks = 0;
		step_no = 0;
		first_step = 0;
		got = 0;
		run_on = 1'b0;
		monitor_on = 1'b0;
		void'($urandom(32'h4624_9125));
		for (int i = 0; i < MEM_WORDS; i++) begin
			cases_mem[i] = '0;
		end
		$readmemh("verif/fir_cases.txt", cases_mem);
		ptr = 0;
		num_cases = 0;
		total = 0;
		while (ptr < MEM_WORDS && cases_mem[ptr] != 0) begin
			num_cases++;
			total += cases_mem[ptr];
			ptr += 1 + NUM_UNIQ + 2 * cases_mem[ptr];
		end
		if (num_cases == 0) begin
			errors++;
			$display("no test cases found in the cases file");
		end
		limit_ns = 20 * (2 * longint'(total + num_cases * (LATENCY + 10)) * GAP_ALLOW
			+ 2 * num_cases * REG_CYCLES + 100);
		fork
			begin
				#(limit_ns * 1ns);
				$display("timeout: the run did not finish within %0d ns", limit_ns);
				$display("checks: %0d, errors: %0d", checks, errors);
				$display("Verification failed");
				$finish;
			end
		join_none
		for (int pass = 0; pass < 2; pass++) begin
			ptr = 0;
			for (int c = 0; c < num_cases; c++) begin
				run_case(ptr, pass == 1);
				ptr += 1 + NUM_UNIQ + 2 * cases_mem[ptr];
			end
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- verif/fir_cases.txt
// each case: sample count N, then 9 coefficients c(0)..c(8),
// then N input samples, then N expected outputs; all 32-bit hex, count 0 ends
// case 1: impulse of 2^16, outputs c(t)/2 for t = 0..16
11
FFFFFC18 000007D0 FFFFF448 00000FA0 00001770 00002710 00004E20 00009C40 0000EA60
00010000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000
FFFFFE0C 000003E8 FFFFFA24 000007D0 00000BB8 00001388 00002710 00004E20
00007530 00004E20 00002710 00001388 00000BB8 000007D0 FFFFFA24 000003E8
FFFFFE0C
// case 2: mixed stream, coefficients 1, -2, 3 times 2^13
14
00002000 FFFFC000 00006000 00000000 00000000 00000000 00000000 00000000 00000000
00000064 FFFFFFCE 0000001E 000000C8 FFFFFF88 00000007 00000000 00000040
FFFFFFDF 0000005A 0000000F FFFFFF38 0000002D 0000000B FFFFFFBA 00000082
FFFFFFFB 0000003C 00000019 FFFFFFB0
00000006 FFFFFFF0 0000001A FFFFFFFF FFFFFFE5 00000034 FFFFFFE8 00000005
FFFFFFF5 00000015 FFFFFFEF 00000002 0000001E FFFFFFD5 00000015 FFFFFFFD
FFFFFFF4 0000003B FFFFFFCB 0000001F
// case 3: full scale inputs, outputs clamp at both rails
10
0001FFFF 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0001FFFF
0001FFFF 0001FFFF 0001FFFF 0001FFFF FFFE0000 FFFE0000 FFFE0000 FFFE0000
0001FFFF 0001FFFF 0001FFFF 0001FFFF FFFE0000 FFFE0000 FFFE0000 FFFE0000
0001FFFE 0001FFFE 0001FFFE 0001FFFE FFFE0001 FFFE0001 FFFE0001 FFFE0001
0001FFFF 0001FFFF 0001FFFF 0001FFFF FFFE0000 FFFE0000 FFFE0000 FFFE0000
// end of cases
00000000

//--- src.f
common/fir_pkg.sv
fir/fir_tap_line.sv
fir/fir_mac_tree.sv
fir/fir_core.sv
hw/fir_coef_regs.sv
hw/fir_top.sv
verif/fir_tb.sv

//--- Makefile
# Verilator build and run for the FIR filter testbench

SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vfir_tb: src.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module fir_tb -f src.f -o Vfir_tb

sim.log: obj_dir/Vfir_tb verif/fir_cases.txt
	./obj_dir/Vfir_tb > sim.log 2>&1 || true

run: obj_dir/Vfir_tb
	./obj_dir/Vfir_tb 2>&1 | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
